// ==== common/rv_decode_settings.svh ====
// RV64 decode widths and major opcodes, included by every decode-stage RTL file
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// datapath and instruction widths
`define RV_XLEN        64       // integer register width
`define RV_INST_W      32       // base instruction length
`define RV_REG_ADDR_W  5        // x0..x31 index
`define RV_NUM_GPR     32       // architectural registers

// major opcodes, inst[6:0]
`define RV_OPC_LOAD       7'b0000011
`define RV_OPC_STORE      7'b0100011
`define RV_OPC_BRANCH     7'b1100011
`define RV_OPC_JAL        7'b1101111
`define RV_OPC_JALR       7'b1100111
`define RV_OPC_LUI        7'b0110111
`define RV_OPC_AUIPC      7'b0010111
`define RV_OPC_OP         7'b0110011   // reg-reg alu
`define RV_OPC_OP_IMM     7'b0010011   // reg-imm alu
`define RV_OPC_OP_32      7'b0111011   // word reg-reg
`define RV_OPC_OP_IMM_32  7'b0011011   // word reg-imm

`endif

// ==== common/rv_decode_pkg.sv ====
// shared decode types: instruction format views, operation classes, immediate formats
`default_nettype none

package rv_decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;     // sign in bit 11
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;       // sits where rd would be
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;        // odd one out, inst[7]
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, six readings
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_t;

    typedef enum logic [3:0] {
        op_illegal   = 4'd0,
        op_lui       = 4'd1,
        op_auipc     = 4'd2,
        op_jal       = 4'd3,
        op_jalr      = 4'd4,
        op_branch    = 4'd5,
        op_load      = 4'd6,
        op_store     = 4'd7,
        op_alu_imm   = 4'd8,
        op_alu_reg   = 4'd9,
        op_alu_imm_w = 4'd10,
        op_alu_reg_w = 4'd11
    } op_class_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_sel_e;

endpackage

`default_nettype wire

// ==== hdl/id_latch.sv ====
// fetch/decode pipeline register, holds its instruction on interlock or back-pressure
`default_nettype none
`include "rv_decode_settings.svh"

module id_latch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [`RV_XLEN-1:0]        in_pc,
    input  logic [`RV_INST_W-1:0]      in_inst,
    input  logic                       out_ready,   // from downstream
    input  logic                       stall,       // load-use interlock
    output logic                       in_ready,
    output logic                       dec_valid,
    output logic [`RV_XLEN-1:0]        dec_pc,
    output rv_decode_pkg::inst_word_t  dec_inst
);

    // stage advances only when execute can take us and no interlock
    assign in_ready = out_ready & ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;   // empty slot when upstream idle
        end
    end

    // payload moves with the valid bit
    always_ff @(posedge clk) begin
        if (in_ready) begin
            dec_pc   <= in_pc;
            dec_inst <= in_inst;     // raw word into union view
        end
    end

endmodule

`default_nettype wire

// ==== decode/inst_classifier.sv ====
// RV64I decoder: opcode/funct fields to op class, immediate format and register usage
`default_nettype none
`include "rv_decode_settings.svh"

module inst_classifier (
    input  rv_decode_pkg::inst_word_t  dec_inst,
    output rv_decode_pkg::op_class_e   op_class,
    output rv_decode_pkg::imm_sel_e    imm_sel,
    output logic                       wen,
    output logic                       uses_rs1,
    output logic                       uses_rs2
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = dec_inst.r_fmt.opcode;
    assign funct3 = dec_inst.r_fmt.funct3;
    assign funct7 = dec_inst.r_fmt.funct7;

    // class decode
    always_comb begin
        op_class = rv_decode_pkg::op_illegal;
        case (opcode)
            `RV_OPC_LUI:   op_class = rv_decode_pkg::op_lui;
            `RV_OPC_AUIPC: op_class = rv_decode_pkg::op_auipc;
            `RV_OPC_JAL:   op_class = rv_decode_pkg::op_jal;
            `RV_OPC_JALR: begin
                if (funct3 == 3'b000) op_class = rv_decode_pkg::op_jalr;
            end
            `RV_OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) op_class = rv_decode_pkg::op_branch;   // 010/011 unused
            end
            `RV_OPC_LOAD: begin
                if (funct3 != 3'b111) op_class = rv_decode_pkg::op_load;   // lb..ld, lbu/lhu/lwu
            end
            `RV_OPC_STORE: begin
                if (!funct3[2]) op_class = rv_decode_pkg::op_store;   // sb sh sw sd
            end
            `RV_OPC_OP_IMM: begin
                case (funct3)
                    3'b001:  if (funct7[6:1] == 6'b000000) op_class = rv_decode_pkg::op_alu_imm;
                    3'b101:  if (funct7[6:1] == 6'b000000 || funct7[6:1] == 6'b010000)
                                 op_class = rv_decode_pkg::op_alu_imm;   // srli / srai, 6-bit shamt
                    default: op_class = rv_decode_pkg::op_alu_imm;
                endcase
            end
            `RV_OPC_OP: begin
                if (funct7 == 7'b0000000)
                    op_class = rv_decode_pkg::op_alu_reg;
                else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
                    op_class = rv_decode_pkg::op_alu_reg;                // sub / sra
            end
            `RV_OPC_OP_IMM_32: begin
                case (funct3)
                    3'b000:  op_class = rv_decode_pkg::op_alu_imm_w;   // addiw
                    3'b001:  if (funct7 == 7'b0000000) op_class = rv_decode_pkg::op_alu_imm_w;
                    3'b101:  if (funct7 == 7'b0000000 || funct7 == 7'b0100000)
                                 op_class = rv_decode_pkg::op_alu_imm_w;
                    default: op_class = rv_decode_pkg::op_illegal;
                endcase
            end
            `RV_OPC_OP_32: begin
                case (funct3)
                    3'b000, 3'b101: if (funct7 == 7'b0000000 || funct7 == 7'b0100000)
                                        op_class = rv_decode_pkg::op_alu_reg_w;
                    3'b001:         if (funct7 == 7'b0000000)
                                        op_class = rv_decode_pkg::op_alu_reg_w;   // sllw
                    default:        op_class = rv_decode_pkg::op_illegal;
                endcase
            end
            default: op_class = rv_decode_pkg::op_illegal;
        endcase
    end

    // per-class controls
    always_comb begin
        wen      = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        imm_sel  = rv_decode_pkg::imm_i;
        case (op_class)
            rv_decode_pkg::op_lui, rv_decode_pkg::op_auipc: begin
                uses_rs1 = 1'b0;
                imm_sel  = rv_decode_pkg::imm_u;
            end
            rv_decode_pkg::op_jal: begin
                uses_rs1 = 1'b0;
                imm_sel  = rv_decode_pkg::imm_j;
            end
            rv_decode_pkg::op_branch: begin
                wen      = 1'b0;   // compares only
                uses_rs2 = 1'b1;
                imm_sel  = rv_decode_pkg::imm_b;
            end
            rv_decode_pkg::op_store: begin
                wen      = 1'b0;
                uses_rs2 = 1'b1;   // store data
                imm_sel  = rv_decode_pkg::imm_s;
            end
            rv_decode_pkg::op_alu_reg, rv_decode_pkg::op_alu_reg_w: uses_rs2 = 1'b1;
            rv_decode_pkg::op_illegal: begin
                wen      = 1'b0;   // no side effects
                uses_rs1 = 1'b0;
            end
            default: ;             // jalr, load, alu_imm(_w) keep defaults
        endcase
    end

endmodule

`default_nettype wire

// ==== decode/imm_gen.sv ====
// immediate generator: sign-extended 64-bit immediate in I/S/B/U/J format
`default_nettype none
`include "rv_decode_settings.svh"

module imm_gen (
    input  rv_decode_pkg::inst_word_t  dec_inst,
    input  rv_decode_pkg::imm_sel_e    imm_sel,
    output logic [`RV_XLEN-1:0]        imm
);

    // every format keeps its sign in inst[31]
    always_comb begin
        case (imm_sel)
            rv_decode_pkg::imm_s: begin
                imm = {{(`RV_XLEN-12){dec_inst.s_fmt.imm_11_5[6]}},
                       dec_inst.s_fmt.imm_11_5,
                       dec_inst.s_fmt.imm_4_0};
            end
            rv_decode_pkg::imm_b: begin
                imm = {{(`RV_XLEN-13){dec_inst.b_fmt.imm_12}},
                       dec_inst.b_fmt.imm_12,
                       dec_inst.b_fmt.imm_11,
                       dec_inst.b_fmt.imm_10_5,
                       dec_inst.b_fmt.imm_4_1,
                       1'b0};                                     // halfword aligned
            end
            rv_decode_pkg::imm_u: begin
                imm = {{(`RV_XLEN-32){dec_inst.u_fmt.imm_31_12[19]}},
                       dec_inst.u_fmt.imm_31_12,
                       12'h000};                                  // upper 20 in place
            end
            rv_decode_pkg::imm_j: begin
                imm = {{(`RV_XLEN-21){dec_inst.j_fmt.imm_20}},
                       dec_inst.j_fmt.imm_20,
                       dec_inst.j_fmt.imm_19_12,
                       dec_inst.j_fmt.imm_11,
                       dec_inst.j_fmt.imm_10_1,
                       1'b0};
            end
            default: begin                                        // I format
                imm = {{(`RV_XLEN-12){dec_inst.i_fmt.imm_11_0[11]}},
                       dec_inst.i_fmt.imm_11_0};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/load_use_hazard.sv ====
// load-use interlock: stalls decode while the execute register holds a load it depends on
`default_nettype none
`include "rv_decode_settings.svh"

module load_use_hazard (
    input  logic                       dec_valid,
    input  rv_decode_pkg::inst_word_t  dec_inst,
    input  logic                       uses_rs1,
    input  logic                       uses_rs2,
    input  logic                       ex_valid,
    input  logic                       ex_is_load,
    input  logic [`RV_REG_ADDR_W-1:0]  ex_rd,
    output logic                       stall
);

    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic                      ld_pending;   // load result not back yet
    logic                      rs1_hit;
    logic                      rs2_hit;

    assign rs1 = dec_inst.r_fmt.rs1;
    assign rs2 = dec_inst.r_fmt.rs2;

    // x0 never waits
    assign ld_pending = ex_valid & ex_is_load & (ex_rd != '0);

    assign rs1_hit = uses_rs1 & (rs1 == ex_rd);
    assign rs2_hit = uses_rs2 & (rs2 == ex_rd);   // rs2 field is junk unless used

    assign stall = dec_valid & ld_pending & (rs1_hit | rs2_hit);

endmodule

`default_nettype wire

// ==== hdl/id_ex_reg.sv ====
// decode/execute register: reads the operands, registers decode results, inserts bubbles
`default_nettype none
`include "rv_decode_settings.svh"

module id_ex_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       out_ready,
    input  logic                       stall,
    input  logic                       dec_valid,
    input  logic [`RV_XLEN-1:0]        dec_pc,
    input  rv_decode_pkg::inst_word_t  dec_inst,
    input  rv_decode_pkg::op_class_e   op_class,
    input  logic                       wen,
    input  logic [`RV_XLEN-1:0]        imm,
    input  logic [`RV_XLEN-1:0]        gpr [`RV_NUM_GPR],
    output logic                       out_valid,
    output logic [`RV_XLEN-1:0]        out_pc,
    output logic [`RV_INST_W-1:0]      out_inst,
    output rv_decode_pkg::op_class_e   out_op,
    output logic [`RV_REG_ADDR_W-1:0]  out_rd,
    output logic                       out_wen,
    output logic [`RV_XLEN-1:0]        out_src_a,
    output logic [`RV_XLEN-1:0]        out_src_b,
    output logic [`RV_XLEN-1:0]        out_imm,
    output logic                       ex_valid,
    output logic                       ex_is_load,
    output logic [`RV_REG_ADDR_W-1:0]  ex_rd
);

    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;
    logic                take;      // real instruction moves in

    // operand read, register file owned outside
    assign src_a = gpr[dec_inst.r_fmt.rs1];
    assign src_b = gpr[dec_inst.r_fmt.rs2];

    assign take = dec_valid & ~stall;   // stall turns the slot into a bubble

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_wen   <= 1'b0;
        end else if (out_ready) begin
            out_valid <= take;
            out_wen   <= take & wen;   // bubbles never write back
        end
    end

    // payload follows the slot, contents of a bubble don't matter
    always_ff @(posedge clk) begin
        if (out_ready) begin
            out_pc    <= dec_pc;
            out_inst  <= dec_inst;
            out_op    <= op_class;
            out_rd    <= dec_inst.r_fmt.rd;
            out_src_a <= src_a;
            out_src_b <= src_b;
            out_imm   <= imm;
        end
    end

    // feedback to the interlock
    assign ex_valid   = out_valid;
    assign ex_is_load = (out_op == rv_decode_pkg::op_load);
    assign ex_rd      = out_rd;

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
// decode stage top: fetch/decode register, decoder, interlock and execute register
`default_nettype none
`include "rv_decode_settings.svh"

module id_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`RV_XLEN-1:0]        in_pc,
    input  logic [`RV_INST_W-1:0]      in_inst,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`RV_XLEN-1:0]        out_pc,
    output logic [`RV_INST_W-1:0]      out_inst,
    output rv_decode_pkg::op_class_e   out_op,
    output logic [`RV_REG_ADDR_W-1:0]  out_rd,
    output logic                       out_wen,
    output logic [`RV_XLEN-1:0]        out_src_a,
    output logic [`RV_XLEN-1:0]        out_src_b,
    output logic [`RV_XLEN-1:0]        out_imm,
    input  logic [`RV_XLEN-1:0]        gpr [`RV_NUM_GPR]
);

    logic                       dec_valid;
    logic [`RV_XLEN-1:0]        dec_pc;
    rv_decode_pkg::inst_word_t  dec_inst;
    rv_decode_pkg::op_class_e   op_class;
    rv_decode_pkg::imm_sel_e    imm_sel;
    logic                       wen;
    logic                       uses_rs1;
    logic                       uses_rs2;
    logic [`RV_XLEN-1:0]        imm;
    logic                       stall;
    logic                       ex_valid;
    logic                       ex_is_load;
    logic [`RV_REG_ADDR_W-1:0]  ex_rd;

    id_latch i_latch (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .out_ready (out_ready),
        .stall     (stall),
        .in_ready  (in_ready),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_inst  (dec_inst)
    );

    inst_classifier i_classifier (
        .dec_inst (dec_inst),
        .op_class (op_class),
        .imm_sel  (imm_sel),
        .wen      (wen),
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2)
    );

    imm_gen i_imm_gen (
        .dec_inst (dec_inst),
        .imm_sel  (imm_sel),
        .imm      (imm)
    );

    load_use_hazard i_hazard (
        .dec_valid  (dec_valid),
        .dec_inst   (dec_inst),
        .uses_rs1   (uses_rs1),
        .uses_rs2   (uses_rs2),
        .ex_valid   (ex_valid),
        .ex_is_load (ex_is_load),
        .ex_rd      (ex_rd),
        .stall      (stall)
    );

    id_ex_reg i_id_ex (
        .clk        (clk),
        .rst        (rst),
        .out_ready  (out_ready),
        .stall      (stall),
        .dec_valid  (dec_valid),
        .dec_pc     (dec_pc),
        .dec_inst   (dec_inst),
        .op_class   (op_class),
        .wen        (wen),
        .imm        (imm),
        .gpr        (gpr),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_inst   (out_inst),
        .out_op     (out_op),
        .out_rd     (out_rd),
        .out_wen    (out_wen),
        .out_src_a  (out_src_a),
        .out_src_b  (out_src_b),
        .out_imm    (out_imm),
        .ex_valid   (ex_valid),
        .ex_is_load (ex_is_load),
        .ex_rd      (ex_rd)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_id_stage.sv ====
// self-checking testbench for the decode stage, runs the instruction table twice and scores outputs
`default_nettype none
`include "rv_decode_settings.svh"

module tb_id_stage;

    logic                              clk;
    logic                              rst;
    logic                              in_valid;
    logic                              in_ready;
    logic [`RV_XLEN-1:0]               in_pc;
    logic [`RV_INST_W-1:0]             in_inst;
    logic                              out_valid;
    logic                              out_ready;
    logic [`RV_XLEN-1:0]               out_pc;
    logic [`RV_INST_W-1:0]             out_inst;
    rv_decode_pkg::op_class_e          out_op;
    logic [`RV_REG_ADDR_W-1:0]         out_rd;
    logic                              out_wen;
    logic [`RV_XLEN-1:0]               out_src_a;
    logic [`RV_XLEN-1:0]               out_src_b;
    logic [`RV_XLEN-1:0]               out_imm;
    logic [`RV_XLEN-1:0]               gpr [`RV_NUM_GPR];

    // stimulus table, one entry per test
    string                             t_name [$];
    logic [`RV_INST_W-1:0]             t_inst [$];
    logic [`RV_XLEN-1:0]               t_pc [$];
    rv_decode_pkg::op_class_e          t_op [$];
    logic                              t_wen [$];
    logic [`RV_XLEN-1:0]               t_imm [$];
    int                                t_gap [$];   // bubbles before this entry, ready held high

    int          accept_q [$];      // cycle of each accepted input
    int          cycle = 0;
    int          seen = 0;          // outputs scored in this run
    int          idle = 0;          // empty output cycles since last transfer
    int          phase = 0;
    int          err_cnt = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    logic        test_bad;
    logic        timing_on = 1'b0;  // latency and gap checks, ready held high only
    logic        random_ready = 1'b0;
    logic [31:0] lcg_state = 32'd99;

    id_stage i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .out_op    (out_op),
        .out_rd    (out_rd),
        .out_wen   (out_wen),
        .out_src_a (out_src_a),
        .out_src_b (out_src_b),
        .out_imm   (out_imm),
        .gpr       (gpr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // period 40
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // instruction encoders, field order per the base ISA
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
    endfunction

    task automatic add_test(string name, logic [31:0] inst, rv_decode_pkg::op_class_e op,
                            logic wen, logic [63:0] imm, int gap);
        t_pc.push_back(64'h1000 + 4 * t_name.size());   // pc steps by one word
        t_name.push_back(name);
        t_inst.push_back(inst);
        t_op.push_back(op);
        t_wen.push_back(wen);
        t_imm.push_back(imm);
        t_gap.push_back(gap);
    endtask

    task automatic check_field(string test, string field, logic [63:0] exp, logic [63:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", test, field, exp, act);
            err_cnt++;
            test_bad = 1'b1;
        end
    endtask

    // offer each entry, hold it until the stage takes it
    task automatic feed_table();
        for (int i = 0; i < t_name.size(); i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_inst  = t_inst[i];
            in_pc    = t_pc[i];
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    always @(negedge clk) begin : ready_gen
        logic [31:0] r;
        if (random_ready) begin
            r = lcg_next();
            out_ready = (r[17:16] != 2'b00);   // ready about 3 cycles in 4
        end
    end

    // scoreboard, samples on the rising edge where transfers happen
    always @(posedge clk) begin : monitor
        logic [31:0] ins;
        int          lat;
        cycle = cycle + 1;
        if (!rst && in_valid && in_ready) accept_q.push_back(cycle);
        if (!rst && out_valid && out_ready) begin
            assert (seen < t_name.size() && accept_q.size() > 0) else begin
                $display("output transfer with no table entry left for it, pc %h", out_pc);
                err_cnt++;
            end
            if (seen < t_name.size() && accept_q.size() > 0) begin
                ins      = t_inst[seen];
                test_bad = 1'b0;
                lat      = cycle - accept_q.pop_front();
                check_field(t_name[seen], "out_pc", t_pc[seen], out_pc);
                check_field(t_name[seen], "out_inst", ins, out_inst);
                check_field(t_name[seen], "out_op", t_op[seen], out_op);
                check_field(t_name[seen], "out_wen", t_wen[seen], out_wen);
                check_field(t_name[seen], "out_imm", t_imm[seen], out_imm);
                check_field(t_name[seen], "out_rd", ins[11:7], out_rd);
                check_field(t_name[seen], "out_src_a", gpr[ins[19:15]], out_src_a);
                check_field(t_name[seen], "out_src_b", gpr[ins[24:20]], out_src_b);
                if (timing_on) begin
                    check_field(t_name[seen], "latency", 2 + t_gap[seen], lat);
                    if (seen > 0) check_field(t_name[seen], "gap", t_gap[seen], idle);
                end
                tests_run++;
                if (test_bad) tests_bad++;
                $display("run %0d %s %s", phase, t_name[seen], test_bad ? "mismatch" : "ok");
                seen++;
            end
            idle = 0;
        end else if (!out_valid) begin
            idle++;
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = t_name.size() * 8;   // both runs with back-pressure fit easily
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main
        logic [31:0] hi;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        out_ready = 1'b0;
        gpr[0]    = '0;             // x0 reads zero
        for (int i = 1; i < `RV_NUM_GPR; i++) begin
            hi     = lcg_next();
            gpr[i] = {hi, lcg_next()};
        end
        add_test("lui_pos", enc_u(20'h12345, 5'd5, `RV_OPC_LUI),
                 rv_decode_pkg::op_lui, 1'b1, 64'h0000_0000_1234_5000, 0);
        add_test("lui_neg", enc_u(20'hfffff, 5'd6, `RV_OPC_LUI),
                 rv_decode_pkg::op_lui, 1'b1, 64'hffff_ffff_ffff_f000, 0);
        add_test("auipc_neg", enc_u(20'h80000, 5'd7, `RV_OPC_AUIPC),
                 rv_decode_pkg::op_auipc, 1'b1, 64'hffff_ffff_8000_0000, 0);
        add_test("jal_pos", enc_j(21'h000800, 5'd1),
                 rv_decode_pkg::op_jal, 1'b1, 64'h0000_0000_0000_0800, 0);
        add_test("jal_neg", enc_j(21'h1ffffc, 5'd1),
                 rv_decode_pkg::op_jal, 1'b1, 64'hffff_ffff_ffff_fffc, 0);
        add_test("jalr", enc_i(12'h010, 5'd2, 3'd0, 5'd1, `RV_OPC_JALR),
                 rv_decode_pkg::op_jalr, 1'b1, 64'h10, 0);
        add_test("beq_pos", enc_b(13'h0040, 5'd4, 5'd3, 3'd0),
                 rv_decode_pkg::op_branch, 1'b0, 64'h40, 0);
        add_test("bne_neg", enc_b(13'h1ff0, 5'd4, 5'd3, 3'd1),
                 rv_decode_pkg::op_branch, 1'b0, 64'hffff_ffff_ffff_fff0, 0);
        add_test("ld_x8", enc_i(12'hff8, 5'd10, 3'd3, 5'd8, `RV_OPC_LOAD),
                 rv_decode_pkg::op_load, 1'b1, 64'hffff_ffff_ffff_fff8, 0);
        add_test("addi_dep_x8", enc_i(12'h001, 5'd8, 3'd0, 5'd9, `RV_OPC_OP_IMM),
                 rv_decode_pkg::op_alu_imm, 1'b1, 64'h1, 1);          // load-use bubble
        add_test("sd_pos", enc_s(12'h7ff, 5'd9, 5'd2, 3'd3),
                 rv_decode_pkg::op_store, 1'b0, 64'h7ff, 0);
        add_test("sw_neg", enc_s(12'h800, 5'd9, 5'd2, 3'd2),
                 rv_decode_pkg::op_store, 1'b0, 64'hffff_ffff_ffff_f800, 0);
        add_test("ld_x0", enc_i(12'h020, 5'd2, 3'd3, 5'd0, `RV_OPC_LOAD),
                 rv_decode_pkg::op_load, 1'b1, 64'h20, 0);
        add_test("add_x0_x0", enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd11, `RV_OPC_OP),
                 rv_decode_pkg::op_alu_reg, 1'b1, 64'h0, 0);          // x0 never stalls
        add_test("lw_x12", enc_i(12'h004, 5'd3, 3'd2, 5'd12, `RV_OPC_LOAD),
                 rv_decode_pkg::op_load, 1'b1, 64'h4, 0);
        add_test("addi_rs2_x12", enc_i(12'h00c, 5'd1, 3'd0, 5'd13, `RV_OPC_OP_IMM),
                 rv_decode_pkg::op_alu_imm, 1'b1, 64'hc, 0);          // rs2 field unused
        add_test("lwu_x14", enc_i(12'h000, 5'd5, 3'd6, 5'd14, `RV_OPC_LOAD),
                 rv_decode_pkg::op_load, 1'b1, 64'h0, 0);
        add_test("sub_dep_x14", enc_r(7'h20, 5'd14, 5'd1, 3'd0, 5'd15, `RV_OPC_OP),
                 rv_decode_pkg::op_alu_reg, 1'b1, 64'h40e, 1);        // hit on rs2
        add_test("addiw_neg", enc_i(12'hfff, 5'd4, 3'd0, 5'd16, `RV_OPC_OP_IMM_32),
                 rv_decode_pkg::op_alu_imm_w, 1'b1, 64'hffff_ffff_ffff_ffff, 0);
        add_test("subw", enc_r(7'h20, 5'd6, 5'd7, 3'd0, 5'd17, `RV_OPC_OP_32),
                 rv_decode_pkg::op_alu_reg_w, 1'b1, 64'h406, 0);
        add_test("srai", enc_i(12'h403, 5'd2, 3'd5, 5'd18, `RV_OPC_OP_IMM),
                 rv_decode_pkg::op_alu_imm, 1'b1, 64'h403, 0);
        add_test("bad_opcode", 32'h0000_007f,
                 rv_decode_pkg::op_illegal, 1'b0, 64'h0, 0);
        add_test("mul_not_rv64i", enc_r(7'h01, 5'd2, 5'd3, 3'd0, 5'd19, `RV_OPC_OP),
                 rv_decode_pkg::op_illegal, 1'b0, 64'h22, 0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle stage after reset, in_ready tracks out_ready
        @(posedge clk);
        test_bad = 1'b0;
        check_field("reset", "out_valid", 0, out_valid);
        check_field("reset", "in_ready", 0, in_ready);
        @(negedge clk);
        out_ready = 1'b1;
        @(posedge clk);
        check_field("reset", "out_valid", 0, out_valid);
        check_field("reset", "in_ready", 1, in_ready);
        tests_run++;
        if (test_bad) tests_bad++;
        $display("run %0d %s %s", phase, "reset", test_bad ? "mismatch" : "ok");

        @(negedge clk);
        phase     = 1;
        timing_on = 1'b1;
        feed_table();
        wait (seen == t_name.size());

        // second run under random back-pressure, order and values only
        @(posedge clk);
        random_ready = 1'b1;
        @(negedge clk);
        phase     = 2;
        timing_on = 1'b0;
        seen      = 0;
        feed_table();
        wait (seen == t_name.size());

        // a few quiet cycles so a stray extra output still hits the scoreboard
        repeat (4) @(negedge clk);
        $display("tests run %0d, tests with mismatches %0d, failed checks %0d",
                 tests_run, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== id_stage.f ====
+incdir+common
common/rv_decode_pkg.sv
hdl/id_latch.sv
decode/inst_classifier.sv
decode/imm_gen.sv
hdl/load_use_hazard.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
testbench/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - include_dirs:
      - common
    files:
      - common/rv_decode_pkg.sv
      - hdl/id_latch.sv
      - decode/inst_classifier.sv
      - decode/imm_gen.sv
      - hdl/load_use_hazard.sv
      - hdl/id_ex_reg.sv
      - hdl/id_stage.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_id_stage.sv
